// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module spritegen_tb -Mdir obj_dir -o spritegen_sim

run: compile
	./obj_dir/spritegen_sim | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+logic
logic/sprite_pkg.sv
logic/sprite_bus_if.sv
logic/cpu_port.sv
logic/sprite_ram_arbiter.sv
logic/sprite_ram.sv
logic/sprite_scanner.sv
logic/spritegen_subsystem.sv
verification/spritegen_assert.sv
verification/spritegen_tb.sv

// File: logic/cpu_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module cpu_port import sprite_pkg::*; #(
	parameter bit MAIN_CPU = 1'b1
) (
	input  logic      clk_6m,
	input  logic      reset,
	input  logic      valid,
	input  logic      we,
	input  cpu_addr_t addr,
	input  byte_t     wdata,
	output logic      credit,
	output logic      rvalid,
	output byte_t     rdata,
	sprite_bus_if.requester bus
);

	localparam int DEPTH = `SPR_CPU_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(`SPR_QUEUE_DEPTH + 1);

	ram_addr_t        remap_addr;
	logic             buf_we    [DEPTH];
	ram_addr_t        buf_addr  [DEPTH];
	byte_t            buf_wdata [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] arb_credits;
	logic             fwd;

	////////////////////////////////////////
	// Address remap
	////////////////////////////////////////

	// Main CPU always hits the register region, word index from A11..A1
	// Sub CPU puts A0 on RAM A12 and A12 on RAM A11
	assign remap_addr = MAIN_CPU ?
		(ram_addr_t'(`SPR_REG_BASE) | ram_addr_t'(addr[11:1])) :
		{addr[0], addr[12], addr[11:1]};

	////////////////////////////////////////
	// Input buffer toward the arbiter
	////////////////////////////////////////

	// Head leaves only while the arbiter queue has room for it
	assign fwd = (count != '0) && (arb_credits != '0);

	assign bus.req_valid = fwd;
	assign bus.req_we    = buf_we[rd_ptr];
	assign bus.req_addr  = buf_addr[rd_ptr];
	assign bus.req_wdata = buf_wdata[rd_ptr];

	// Freed buffer slot goes back to the outside master
	assign credit = fwd;

	// Responses come back in order, straight through
	assign rvalid = bus.rsp_valid;
	assign rdata  = bus.rsp_data;

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			arb_credits <= CRD_W'(`SPR_QUEUE_DEPTH);
		end else begin
			if (valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (fwd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(valid) - CNT_W'(fwd);
			// Spend on forward, refill on each granted slot
			arb_credits <= arb_credits - CRD_W'(fwd) + CRD_W'(bus.credit_return);
		end
	end

	// Buffer payload
	always_ff @(posedge clk_6m) begin
		if (valid) begin
			buf_we[wr_ptr]    <= we;
			buf_addr[wr_ptr]  <= remap_addr;
			buf_wdata[wr_ptr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: logic/sprite_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sprite_bus_if import sprite_pkg::*; ();

	// Request side, one pulse per spent credit
	logic      req_valid;
	logic      req_we;
	ram_addr_t req_addr;
	byte_t     req_wdata;

	// Queue slot freed in the arbiter
	logic      credit_return;

	// Read data, one cycle after the grant
	logic      rsp_valid;
	byte_t     rsp_data;

	modport requester (
		output req_valid,
		output req_we,
		output req_addr,
		output req_wdata,
		input  credit_return,
		input  rsp_valid,
		input  rsp_data
	);

	modport arbiter (
		input  req_valid,
		input  req_we,
		input  req_addr,
		input  req_wdata,
		output credit_return,
		output rsp_valid,
		output rsp_data
	);

endinterface

`default_nettype wire

// File: logic/sprite_params.svh
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// Sprite RAM geometry, 8 KB
`define SPR_RAM_AW 13
`define SPR_RAM_BYTES (1 << `SPR_RAM_AW)

// Arbiter queue slots per requester, also the starting credits of each requester
`define SPR_QUEUE_DEPTH 2

// CPU port input buffer slots, also the starting credits of the outside master
`define SPR_CPU_CREDITS 2

// Sprite attribute table
`define SPR_COUNT 64
`define SPR_REG_BASE 13'h1800

`endif

// File: logic/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

`include "sprite_params.svh"

	// RAM side address, remapped from the CPU view
	typedef logic [`SPR_RAM_AW-1:0] ram_addr_t;

	// CPU side address as seen on the board bus
	typedef logic [12:0] cpu_addr_t;

	typedef logic [7:0] byte_t;

	// Index into the 64 entry attribute table
	typedef logic [5:0] sprite_idx_t;

	// Sprite priority and current layer level
	typedef logic [2:0] prio_t;

	// Pattern PROM address, sprite index then 5-bit code
	typedef logic [10:0] pattern_addr_t;

	// Scanner sequencing
	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_ISSUE,
		SCAN_WAIT,
		SCAN_DONE
	} scan_state_t;

endpackage

`default_nettype wire

// File: logic/sprite_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module sprite_ram import sprite_pkg::*; (
	input  logic      clk_6m,
	input  logic      en,
	input  logic      we,
	input  ram_addr_t addr,
	input  byte_t     wdata,
	output byte_t     rdata
);

	// 8 KB array, low half general and high half with the sprite registers
	byte_t mem [`SPR_RAM_BYTES];

	// Single port, write at the edge, read data one cycle later
	always_ff @(posedge clk_6m) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: logic/sprite_ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module sprite_ram_arbiter import sprite_pkg::*; (
	input  logic      clk_6m,
	input  logic      reset,
	sprite_bus_if.arbiter main_bus,
	sprite_bus_if.arbiter sub_bus,
	sprite_bus_if.arbiter scan_bus,
	output logic      ram_en,
	output logic      ram_we,
	output ram_addr_t ram_addr,
	output byte_t     ram_wdata,
	input  byte_t     ram_rdata
);

	localparam int NUM_REQ = 3;
	localparam int DEPTH   = `SPR_QUEUE_DEPTH;
	localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W   = $clog2(DEPTH + 1);

	// Requester slots
	localparam logic [1:0] REQ_MAIN = 2'd0;
	localparam logic [1:0] REQ_SUB  = 2'd1;
	localparam logic [1:0] REQ_SCAN = 2'd2;

	logic [NUM_REQ-1:0] in_valid;
	logic [NUM_REQ-1:0] in_we;
	ram_addr_t          in_addr  [NUM_REQ];
	byte_t              in_wdata [NUM_REQ];

	logic               q_we     [NUM_REQ][DEPTH];
	ram_addr_t          q_addr   [NUM_REQ][DEPTH];
	byte_t              q_wdata  [NUM_REQ][DEPTH];
	logic [PTR_W-1:0]   q_wr_ptr [NUM_REQ];
	logic [PTR_W-1:0]   q_rd_ptr [NUM_REQ];
	logic [CNT_W-1:0]   q_count  [NUM_REQ];
	logic [NUM_REQ-1:0] q_busy;

	logic [1:0]         rr_ptr;
	logic [2:0]         cand_sum;
	logic [1:0]         cand;
	logic               grant_valid;
	logic [1:0]         grant_idx;
	logic [NUM_REQ-1:0] credit_ret;
	logic               rd_pending;
	logic [1:0]         rd_owner;

	// Gather the three buses into indexed form
	assign in_valid = {scan_bus.req_valid, sub_bus.req_valid, main_bus.req_valid};
	assign in_we    = {scan_bus.req_we, sub_bus.req_we, main_bus.req_we};
	assign in_addr[REQ_MAIN]  = main_bus.req_addr;
	assign in_addr[REQ_SUB]   = sub_bus.req_addr;
	assign in_addr[REQ_SCAN]  = scan_bus.req_addr;
	assign in_wdata[REQ_MAIN] = main_bus.req_wdata;
	assign in_wdata[REQ_SUB]  = sub_bus.req_wdata;
	assign in_wdata[REQ_SCAN] = scan_bus.req_wdata;

	////////////////////////////////////////
	// Round-robin grant
	////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < NUM_REQ; i++)
			q_busy[i] = (q_count[i] != '0);
	end

	// Search starts at rr_ptr, first busy queue wins
	always_comb begin
		grant_valid = 1'b0;
		grant_idx   = rr_ptr;
		cand_sum    = '0;
		cand        = '0;
		for (int k = 0; k < NUM_REQ; k++) begin
			cand_sum = {1'b0, rr_ptr} + 3'(k);
			cand = (cand_sum >= 3'(NUM_REQ)) ? 2'(cand_sum - 3'(NUM_REQ)) : cand_sum[1:0];
			if (!grant_valid && q_busy[cand]) begin
				grant_valid = 1'b1;
				grant_idx   = cand;
			end
		end
	end

	// Granting an entry frees its slot
	always_comb begin
		for (int i = 0; i < NUM_REQ; i++)
			credit_ret[i] = grant_valid && (grant_idx == 2'(i));
	end

	// Winner's head entry drives the RAM in the grant cycle
	assign ram_en    = grant_valid;
	assign ram_we    = grant_valid && q_we[grant_idx][q_rd_ptr[grant_idx]];
	assign ram_addr  = q_addr[grant_idx][q_rd_ptr[grant_idx]];
	assign ram_wdata = q_wdata[grant_idx][q_rd_ptr[grant_idx]];

	////////////////////////////////////////
	// Queue control and read tracking
	////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			for (int i = 0; i < NUM_REQ; i++) begin
				q_wr_ptr[i] <= '0;
				q_rd_ptr[i] <= '0;
				q_count[i]  <= '0;
			end
			rr_ptr     <= '0;
			rd_pending <= 1'b0;
			rd_owner   <= '0;
		end else begin
			for (int i = 0; i < NUM_REQ; i++) begin
				if (in_valid[i])
					q_wr_ptr[i] <= (q_wr_ptr[i] == PTR_W'(DEPTH - 1)) ? '0 : q_wr_ptr[i] + 1'b1;
				if (credit_ret[i])
					q_rd_ptr[i] <= (q_rd_ptr[i] == PTR_W'(DEPTH - 1)) ? '0 : q_rd_ptr[i] + 1'b1;
				q_count[i] <= q_count[i] + CNT_W'(in_valid[i]) - CNT_W'(credit_ret[i]);
			end
			// Pointer moves one past the winner
			if (grant_valid)
				rr_ptr <= (grant_idx == 2'(NUM_REQ - 1)) ? '0 : grant_idx + 1'b1;
			// Read data shows up next cycle, remember who asked
			rd_pending <= grant_valid && !ram_we;
			if (grant_valid)
				rd_owner <= grant_idx;
		end
	end

	// Queue payload
	always_ff @(posedge clk_6m) begin
		for (int i = 0; i < NUM_REQ; i++) begin
			if (in_valid[i]) begin
				q_we[i][q_wr_ptr[i]]    <= in_we[i];
				q_addr[i][q_wr_ptr[i]]  <= in_addr[i];
				q_wdata[i][q_wr_ptr[i]] <= in_wdata[i];
			end
		end
	end

	// Credits and responses back to each requester
	assign main_bus.credit_return = credit_ret[REQ_MAIN];
	assign sub_bus.credit_return  = credit_ret[REQ_SUB];
	assign scan_bus.credit_return = credit_ret[REQ_SCAN];

	assign main_bus.rsp_valid = rd_pending && (rd_owner == REQ_MAIN);
	assign sub_bus.rsp_valid  = rd_pending && (rd_owner == REQ_SUB);
	assign scan_bus.rsp_valid = rd_pending && (rd_owner == REQ_SCAN);
	assign main_bus.rsp_data  = ram_rdata;
	assign sub_bus.rsp_data   = ram_rdata;
	assign scan_bus.rsp_data  = ram_rdata;

endmodule

`default_nettype wire

// File: logic/sprite_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module sprite_scanner import sprite_pkg::*; (
	input  logic          clk_6m,
	input  logic          reset,
	input  logic          scan_start,
	input  prio_t         spr,
	output logic          obj_valid,
	output pattern_addr_t obj_addr,
	output logic          scan_done,
	sprite_bus_if.requester bus
);

	localparam int          CRD_W = $clog2(`SPR_QUEUE_DEPTH + 1);
	localparam sprite_idx_t LAST  = sprite_idx_t'(`SPR_COUNT - 1);

	scan_state_t      state;
	prio_t            spr_q;
	sprite_idx_t      issue_idx;
	sprite_idx_t      rsp_idx;
	logic [CRD_W-1:0] credits;
	logic             issue;

	////////////////////////////////////////
	// Attribute reads
	////////////////////////////////////////

	// Keep reading while queue credits last
	assign issue = (state == SCAN_ISSUE) && (credits != '0);

	assign bus.req_valid = issue;
	assign bus.req_we    = 1'b0;
	assign bus.req_addr  = ram_addr_t'(`SPR_REG_BASE) + ram_addr_t'(issue_idx);
	assign bus.req_wdata = '0;

	assign scan_done = (state == SCAN_DONE);

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			state     <= SCAN_IDLE;
			issue_idx <= '0;
			rsp_idx   <= '0;
			credits   <= CRD_W'(`SPR_QUEUE_DEPTH);
			obj_valid <= 1'b0;
		end else begin
			credits <= credits - CRD_W'(issue) + CRD_W'(bus.credit_return);
			// Both indices wrap to zero after sprite 63, ready for the next scan
			if (issue)
				issue_idx <= issue_idx + 1'b1;
			if (bus.rsp_valid)
				rsp_idx <= rsp_idx + 1'b1;
			// Sprite is drawn only above the current layer
			obj_valid <= bus.rsp_valid && (bus.rsp_data[2:0] > spr_q);
			case (state)
				SCAN_IDLE:
					if (scan_start)
						state <= SCAN_ISSUE;
				SCAN_ISSUE:
					if (issue && issue_idx == LAST)
						state <= SCAN_WAIT;
				SCAN_WAIT:
					if (bus.rsp_valid && rsp_idx == LAST)
						state <= SCAN_DONE;
				SCAN_DONE:
					state <= SCAN_IDLE;
				default:
					state <= SCAN_IDLE;
			endcase
		end
	end

	// Layer level held for the whole scan, start pulses mid scan ignored
	always_ff @(posedge clk_6m) begin
		if (state == SCAN_IDLE && scan_start)
			spr_q <= spr;
		// PROM address is index then code from bits 7..3
		if (bus.rsp_valid)
			obj_addr <= {rsp_idx, bus.rsp_data[7:3]};
	end

endmodule

`default_nettype wire

// File: logic/spritegen_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module spritegen_subsystem import sprite_pkg::*; (
	input  logic          clk_6m,
	input  logic          reset,
	// Main CPU
	input  logic          main_valid,
	input  logic          main_we,
	input  cpu_addr_t     main_addr,
	input  byte_t         main_wdata,
	output logic          main_credit,
	output logic          main_rvalid,
	output byte_t         main_rdata,
	// Sub CPU
	input  logic          sub_valid,
	input  logic          sub_we,
	input  cpu_addr_t     sub_addr,
	input  byte_t         sub_wdata,
	output logic          sub_credit,
	output logic          sub_rvalid,
	output byte_t         sub_rdata,
	// Sprite scan
	input  logic          scan_start,
	input  prio_t         spr,
	output logic          obj_valid,
	output pattern_addr_t obj_addr,
	output logic          scan_done
);

	logic      ram_en;
	logic      ram_we;
	ram_addr_t ram_addr;
	byte_t     ram_wdata;
	byte_t     ram_rdata;

	// One bus per RAM requester
	sprite_bus_if main_if ();
	sprite_bus_if sub_if ();
	sprite_bus_if scan_if ();

	////////////////////////////////////////
	// Requesters
	////////////////////////////////////////

	cpu_port #(.MAIN_CPU(1'b1)) main_port (
		.clk_6m (clk_6m),
		.reset  (reset),
		.valid  (main_valid),
		.we     (main_we),
		.addr   (main_addr),
		.wdata  (main_wdata),
		.credit (main_credit),
		.rvalid (main_rvalid),
		.rdata  (main_rdata),
		.bus    (main_if.requester)
	);

	cpu_port #(.MAIN_CPU(1'b0)) sub_port (
		.clk_6m (clk_6m),
		.reset  (reset),
		.valid  (sub_valid),
		.we     (sub_we),
		.addr   (sub_addr),
		.wdata  (sub_wdata),
		.credit (sub_credit),
		.rvalid (sub_rvalid),
		.rdata  (sub_rdata),
		.bus    (sub_if.requester)
	);

	sprite_scanner scanner (
		.clk_6m     (clk_6m),
		.reset      (reset),
		.scan_start (scan_start),
		.spr        (spr),
		.obj_valid  (obj_valid),
		.obj_addr   (obj_addr),
		.scan_done  (scan_done),
		.bus        (scan_if.requester)
	);

	////////////////////////////////////////
	// Shared RAM
	////////////////////////////////////////

	sprite_ram_arbiter arbiter (
		.clk_6m    (clk_6m),
		.reset     (reset),
		.main_bus  (main_if.arbiter),
		.sub_bus   (sub_if.arbiter),
		.scan_bus  (scan_if.arbiter),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	sprite_ram ram (
		.clk_6m (clk_6m),
		.en     (ram_en),
		.we     (ram_we),
		.addr   (ram_addr),
		.wdata  (ram_wdata),
		.rdata  (ram_rdata)
	);

endmodule

`default_nettype wire

// File: verification/spritegen_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module spritegen_assert #(
	parameter int CNT_W = $clog2(`SPR_QUEUE_DEPTH + 1)
) (
	input  logic             clk_6m,
	input  logic             reset,
	input  logic [CNT_W-1:0] q_count_main,
	input  logic [CNT_W-1:0] q_count_sub,
	input  logic [CNT_W-1:0] q_count_scan,
	input  logic [2:0]       req_valid,
	input  logic [2:0]       credit_ret,
	input  logic             ram_en,
	input  logic             ram_we,
	input  logic [2:0]       rsp_valid
);

	localparam logic [CNT_W-1:0] FULL = CNT_W'(`SPR_QUEUE_DEPTH);

	// Entries each requester has sent and the arbiter has not yet granted
	logic [CNT_W-1:0] occ [3];

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			for (int i = 0; i < 3; i++)
				occ[i] <= '0;
		end else begin
			for (int i = 0; i < 3; i++)
				occ[i] <= occ[i] + CNT_W'(req_valid[i]) - CNT_W'(credit_ret[i]);
		end
	end

	////////////////////////////////////////
	// Queue occupancy
	////////////////////////////////////////

	a_main_depth: assert property (@(posedge clk_6m) disable iff (reset)
		q_count_main <= FULL) else $error("main queue holds more than its depth");
	a_sub_depth: assert property (@(posedge clk_6m) disable iff (reset)
		q_count_sub <= FULL) else $error("sub queue holds more than its depth");
	a_scan_depth: assert property (@(posedge clk_6m) disable iff (reset)
		q_count_scan <= FULL) else $error("scan queue holds more than its depth");

	// Read data only in the cycle after a read grant to the same requester
	a_main_rsp: assert property (@(posedge clk_6m) disable iff (reset)
		rsp_valid[0] |-> $past(credit_ret[0] && ram_en && !ram_we))
		else $error("main read response without a main read grant");
	a_sub_rsp: assert property (@(posedge clk_6m) disable iff (reset)
		rsp_valid[1] |-> $past(credit_ret[1] && ram_en && !ram_we))
		else $error("sub read response without a sub read grant");
	a_scan_rsp: assert property (@(posedge clk_6m) disable iff (reset)
		rsp_valid[2] |-> $past(credit_ret[2] && ram_en && !ram_we))
		else $error("scan read response without a scan read grant");

	////////////////////////////////////////
	// Credit return
	////////////////////////////////////////

	// A slot can only be freed for a requester with an entry still waiting
	a_main_credit: assert property (@(posedge clk_6m) disable iff (reset)
		credit_ret[0] |-> occ[0] != '0) else $error("main credit from empty queue");
	a_sub_credit: assert property (@(posedge clk_6m) disable iff (reset)
		credit_ret[1] |-> occ[1] != '0) else $error("sub credit from empty queue");
	a_scan_credit: assert property (@(posedge clk_6m) disable iff (reset)
		credit_ret[2] |-> occ[2] != '0) else $error("scan credit from empty queue");

endmodule

bind sprite_ram_arbiter spritegen_assert assert0 (
	.clk_6m       (clk_6m),
	.reset        (reset),
	.q_count_main (q_count[0]),
	.q_count_sub  (q_count[1]),
	.q_count_scan (q_count[2]),
	.req_valid    (in_valid),
	.credit_ret   (credit_ret),
	.ram_en       (ram_en),
	.ram_we       (ram_we),
	.rsp_valid    ({scan_bus.rsp_valid, sub_bus.rsp_valid, main_bus.rsp_valid})
);

`default_nettype wire

// File: verification/spritegen_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module spritegen_tb import sprite_pkg::*; ();

	logic          clk_6m;
	logic          reset;
	logic          main_valid;
	logic          main_we;
	cpu_addr_t     main_addr;
	byte_t         main_wdata;
	logic          main_credit;
	logic          main_rvalid;
	byte_t         main_rdata;
	logic          sub_valid;
	logic          sub_we;
	cpu_addr_t     sub_addr;
	byte_t         sub_wdata;
	logic          sub_credit;
	logic          sub_rvalid;
	byte_t         sub_rdata;
	logic          scan_start;
	prio_t         spr;
	logic          obj_valid;
	pattern_addr_t obj_addr;
	logic          scan_done;

	// Stimulus table with one row per request and port 2 for a scan start
	string     row_name [$];
	int        row_port [$];
	bit        row_we   [$];
	cpu_addr_t row_addr [$];
	byte_t     row_data [$];
	byte_t     row_exp  [$];

	// Reference RAM as the CPUs should see it
	byte_t     ref_mem [`SPR_RAM_BYTES];

	int        credits [2];
	int        rd_main_q [$];
	int        rd_sub_q  [$];
	// Expected pattern addresses with bit 11 set on each end of scan marker
	logic [11:0] exp_obj [$];
	int        scans_started;
	int        scans_done;
	int        n_scans;
	string     cur_scan;

	spritegen_subsystem dut0 (.*);

	initial begin
		clk_6m = 1'b0;
		forever #5 clk_6m = ~clk_6m;
	end

	////////////////////////////////////////
	// Reference helpers
	////////////////////////////////////////

	// Main lands in the register region and sub moves A0 and A12 to the top
	function automatic ram_addr_t remap(input int port, input cpu_addr_t a);
		ram_addr_t word;
		word = (a >> 1) & 13'h07ff;
		if (port == 0)
			return ram_addr_t'(`SPR_REG_BASE) + word;
		return (a[0] ? 13'h1000 : 13'h0000) + (a[12] ? 13'h0800 : 13'h0000) + word;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			report_failure($sformatf("mismatch %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic add_row(input string name, input int port, input bit we, input cpu_addr_t addr);
		byte_t     d;
		ram_addr_t ra;
		d  = byte_t'($urandom);
		ra = remap(port, addr);
		row_name.push_back(name);
		row_port.push_back(port);
		row_we.push_back(we);
		row_addr.push_back(addr);
		row_data.push_back(d);
		if (we) begin
			ref_mem[ra] = d;
			row_exp.push_back(8'h00);
		end else begin
			row_exp.push_back(ref_mem[ra]);
		end
	endtask

	// Scan expectation comes from the attributes present at this row
	task automatic add_scan(input string name, input prio_t level);
		byte_t b;
		row_name.push_back(name);
		row_port.push_back(2);
		row_we.push_back(1'b0);
		row_addr.push_back('0);
		row_data.push_back(byte_t'(level));
		row_exp.push_back(8'h00);
		for (int i = 0; i < `SPR_COUNT; i++) begin
			b = ref_mem[ram_addr_t'(`SPR_REG_BASE) + ram_addr_t'(i)];
			if (b[2:0] > level)
				exp_obj.push_back({1'b0, 6'(i), b[7:3]});
		end
		exp_obj.push_back(12'h800);
		n_scans++;
	endtask

	task automatic build_table();
		add_row("main_wr_rd", 0, 1, 13'h0100);
		add_row("main_wr_rd", 0, 0, 13'h0100);
		// Odd neighbour hits the same byte
		add_row("main_wr_rd", 0, 0, 13'h0101);
		add_row("main_wr_rd", 0, 1, 13'h0ffe);
		add_row("main_wr_rd", 0, 0, 13'h0fff);
		// A12 and A0 set put a sub write into the register region
		add_row("sub_hi_write", 1, 1, 13'h1021);
		add_row("sub_hi_write", 1, 0, 13'h1021);
		add_row("sub_hi_readback", 0, 0, 13'h0020);
		add_row("sub_bit12_even", 1, 1, 13'h1010);
		add_row("sub_bit12_even", 1, 0, 13'h1010);
		// Odd sub address below 0x1000 stays out of main's view
		add_row("sub_low_odd", 0, 1, 13'h0202);
		add_row("sub_low_odd", 0, 0, 13'h0202);
		add_row("sub_low_odd", 1, 1, 13'h0203);
		add_row("sub_low_odd", 1, 0, 13'h0203);
		add_row("sub_low_check", 0, 0, 13'h0202);
		for (int i = 0; i < 6; i++)
			add_row("burst", 0, 1, cpu_addr_t'(13'h0400 + 2 * i));
		for (int i = 0; i < 6; i++)
			add_row("burst", 0, 0, cpu_addr_t'(13'h0400 + 2 * i));
		// Both CPUs at once on disjoint RAM bytes
		for (int i = 0; i < 8; i++) begin
			add_row("mixed", 0, 1, cpu_addr_t'(13'h0600 + 2 * i));
			add_row("mixed", 1, 1, cpu_addr_t'(13'h0040 + 2 * i));
		end
		for (int i = 0; i < 8; i++) begin
			add_row("mixed", 0, 0, cpu_addr_t'(13'h0600 + 2 * i));
			add_row("mixed", 1, 0, cpu_addr_t'(13'h0040 + 2 * i));
		end
		for (int i = 0; i < `SPR_COUNT; i++)
			add_row("attr_write", 0, 1, cpu_addr_t'(2 * i));
		add_row("attr_write", 0, 0, 13'h007e);
		add_scan("scan_spr3", 3'd3);
		// CPU traffic kept clear of the attribute bytes while scanning
		add_scan("scan_busy", 3'd1);
		for (int i = 0; i < 10; i++) begin
			add_row("scan_busy", 0, 1, cpu_addr_t'(13'h0300 + 2 * i));
			add_row("scan_busy", 1, 1, cpu_addr_t'(13'h0700 + 2 * i));
		end
		for (int i = 0; i < 10; i++) begin
			add_row("scan_busy", 0, 0, cpu_addr_t'(13'h0300 + 2 * i));
			add_row("scan_busy", 1, 0, cpu_addr_t'(13'h0700 + 2 * i));
		end
	endtask

	////////////////////////////////////////
	// Drivers
	////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk_6m);
		#1;
	endtask

	task automatic drain_reads();
		while (rd_main_q.size() != 0 || rd_sub_q.size() != 0)
			next_cycle();
	endtask

	// Holds the request until the master has a credit
	task automatic drive_row(input int i);
		int p;
		p = row_port[i];
		while (credits[p] == 0)
			next_cycle();
		credits[p]--;
		if (p == 0) begin
			main_valid = 1'b1;
			main_we    = row_we[i];
			main_addr  = row_addr[i];
			main_wdata = row_data[i];
			if (!row_we[i])
				rd_main_q.push_back(i);
		end else begin
			sub_valid = 1'b1;
			sub_we    = row_we[i];
			sub_addr  = row_addr[i];
			sub_wdata = row_data[i];
			if (!row_we[i])
				rd_sub_q.push_back(i);
		end
		next_cycle();
		main_valid = 1'b0;
		sub_valid  = 1'b0;
		repeat ($urandom_range(2, 0))
			next_cycle();
	endtask

	task automatic start_scan(input int i);
		while (scans_done != scans_started)
			next_cycle();
		cur_scan   = row_name[i];
		scan_start = 1'b1;
		spr        = prio_t'(row_data[i]);
		scans_started++;
		next_cycle();
		scan_start = 1'b0;
	endtask

	task automatic run_watchdog(input int limit);
		repeat (limit) @(posedge clk_6m);
		report_failure($sformatf("timeout, no end of test after %0d cycles", limit));
	endtask

	////////////////////////////////////////
	// Monitors
	////////////////////////////////////////

	task automatic check_read(input int port, input byte_t data);
		int idx;
		if (port == 0 && rd_main_q.size() == 0) begin
			report_failure("read response on main port with no read outstanding");
		end else if (port == 1 && rd_sub_q.size() == 0) begin
			report_failure("read response on sub port with no read outstanding");
		end else begin
			if (port == 0)
				idx = rd_main_q.pop_front();
			else
				idx = rd_sub_q.pop_front();
			check_value(row_name[idx], 32'(row_exp[idx]), 32'(data));
		end
	endtask

	// Outputs sampled at the edge while inputs change 1 ns later
	always @(posedge clk_6m) begin
		if (!reset) begin
			if (main_credit)
				credits[0]++;
			if (sub_credit)
				credits[1]++;
			if (credits[0] > `SPR_CPU_CREDITS || credits[1] > `SPR_CPU_CREDITS)
				report_failure("CPU port returned more credits than the master spent");
			if (main_rvalid)
				check_read(0, main_rdata);
			if (sub_rvalid)
				check_read(1, sub_rdata);
		end
	end

	// Sprite outputs in index order and then the end marker
	always @(posedge clk_6m) begin
		if (!reset) begin
			if (obj_valid) begin
				if (exp_obj.size() == 0 || exp_obj[0][11])
					report_failure("sprite output that no attribute asks for");
				else
					check_value(cur_scan, 32'(exp_obj.pop_front()), 32'(obj_addr));
			end
			if (scan_done) begin
				if (exp_obj.size() == 0 || !exp_obj[0][11]) begin
					report_failure("scan done before all expected sprites were emitted");
				end else begin
					void'(exp_obj.pop_front());
					scans_done++;
				end
			end
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		reset      = 1'b1;
		main_valid = 1'b0;
		main_we    = 1'b0;
		main_addr  = '0;
		main_wdata = '0;
		sub_valid  = 1'b0;
		sub_we     = 1'b0;
		sub_addr   = '0;
		sub_wdata  = '0;
		scan_start = 1'b0;
		spr        = '0;
		credits[0] = `SPR_CPU_CREDITS;
		credits[1] = `SPR_CPU_CREDITS;
		void'($urandom(32'he943));
		build_table();
		fork
			run_watchdog(row_name.size() * 40 + n_scans * `SPR_COUNT * 20);
		join_none
		repeat (3) @(posedge clk_6m);
		#1;
		reset = 1'b0;
		next_cycle();
		for (int i = 0; i < row_name.size(); i++) begin
			// New test name waits for all reads of the last one
			if (i == 0 || row_name[i] != row_name[i - 1])
				drain_reads();
			if (row_port[i] == 2)
				start_scan(i);
			else
				drive_row(i);
		end
		drain_reads();
		while (scans_done != scans_started)
			next_cycle();
		while (credits[0] != `SPR_CPU_CREDITS || credits[1] != `SPR_CPU_CREDITS)
			next_cycle();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
